/* src/pix_pkg.sv */
package pix_pkg;

    // ======================================================================
    // Sizes
    // ======================================================================
    localparam int PIX_BITS      = 12;
    localparam int WORD_BITS     = 16;
    localparam int IMAGE_WORDS   = 64;
    localparam int WORD_IDX_BITS = $clog2(IMAGE_WORDS);
    localparam int BLOCK_COUNT   = 4;
    localparam int BLOCK_BITS    = 2;
    localparam int FIFO_DEPTH    = 8;
    // One extra bit tells a full FIFO from an empty one
    localparam int FIFO_PTR_BITS = $clog2(FIFO_DEPTH) + 1;

    // ======================================================================
    // Commands and states
    // ======================================================================
    typedef enum logic [1:0] {
        CMD_NONE    = 2'b00,
        CMD_CAPTURE = 2'b01,
        CMD_READOUT = 2'b10,
        CMD_STOP    = 2'b11
    } pix_cmd_e;

    typedef enum logic [1:0] {
        RAM_NONE  = 2'b00,
        RAM_WRITE = 2'b01,
        RAM_READ  = 2'b10,
        RAM_STOP  = 2'b11
    } ram_cmd_e;

    typedef enum logic [1:0] {
        CTRL_IDLE,
        CTRL_CAPTURE,
        CTRL_COPY,
        CTRL_READOUT
    } ctrl_state_e;

    typedef enum logic [1:0] {
        CAP_IDLE,
        CAP_WAIT_INVALID,
        CAP_WAIT_START,
        CAP_STREAM
    } cap_state_e;

endpackage

/* src/toggle_sync.sv */
`timescale 1ns/1ps

module toggle_sync (
    input  logic src_clk,
    input  logic dst_clk,
    input  logic rst_n,
    input  logic src_pulse,
    output logic dst_pulse
);

    logic       src_tgl;
    logic [2:0] dst_sync;

    // Each source pulse flips the level
    always_ff @(posedge src_clk or negedge rst_n) begin
        if (!rst_n) begin
            src_tgl <= 1'b0;
        end else if (src_pulse) begin
            src_tgl <= ~src_tgl;
        end
    end

    // Two synchronizer stages plus one history flop for the edge detect
    always_ff @(posedge dst_clk or negedge rst_n) begin
        if (!rst_n) begin
            dst_sync <= '0;
        end else begin
            dst_sync <= {dst_sync[1:0], src_tgl};
        end
    end

    assign dst_pulse = dst_sync[2] ^ dst_sync[1];

endmodule

/* src/pix_fifo.sv */
`timescale 1ns/1ps

module pix_fifo (
    input  logic                          wr_clk,
    input  logic                          rd_clk,
    input  logic                          rst_n,
    input  logic                          wr_en,
    input  logic [pix_pkg::WORD_BITS-1:0] wr_data,
    input  logic                          rd_en,
    output logic                          full,
    output logic                          rd_valid,
    output logic [pix_pkg::WORD_BITS-1:0] rd_data
);

    logic [pix_pkg::WORD_BITS-1:0]     mem [pix_pkg::FIFO_DEPTH];
    logic [pix_pkg::FIFO_PTR_BITS-1:0] wr_bin;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] wr_gray;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] rd_bin;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] rd_gray;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] wr_gray_s1;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] wr_gray_s2;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] rd_gray_s1;
    logic [pix_pkg::FIFO_PTR_BITS-1:0] rd_gray_s2;
    logic                              wr_push;
    logic                              rd_pop;

    function automatic logic [pix_pkg::FIFO_PTR_BITS-1:0] bin2gray(
        input logic [pix_pkg::FIFO_PTR_BITS-1:0] b
    );
        return b ^ (b >> 1);
    endfunction

    // ======================================================================
    // Write side (wr_clk)
    // ======================================================================
    assign wr_push = wr_en && !full;

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_bin  <= '0;
            wr_gray <= '0;
        end else if (wr_push) begin
            wr_bin  <= wr_bin + 1'b1;
            wr_gray <= bin2gray(wr_bin + 1'b1);
        end
    end

    always_ff @(posedge wr_clk) begin
        if (wr_push) begin
            mem[wr_bin[pix_pkg::FIFO_PTR_BITS-2:0]] <= wr_data;
        end
    end

    always_ff @(posedge wr_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_gray_s1 <= '0;
            rd_gray_s2 <= '0;
        end else begin
            rd_gray_s1 <= rd_gray;
            rd_gray_s2 <= rd_gray_s1;
        end
    end

    // Full when the pointers differ only in the two top Gray bits
    assign full = (wr_gray == {~rd_gray_s2[pix_pkg::FIFO_PTR_BITS-1 -: 2],
                               rd_gray_s2[pix_pkg::FIFO_PTR_BITS-3:0]});

    // ======================================================================
    // Read side (rd_clk)
    // ======================================================================
    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_gray_s1 <= '0;
            wr_gray_s2 <= '0;
        end else begin
            wr_gray_s1 <= wr_gray;
            wr_gray_s2 <= wr_gray_s1;
        end
    end

    assign rd_valid = (rd_gray != wr_gray_s2);
    assign rd_pop   = rd_en && rd_valid;
    // Show-ahead, the head word is on rd_data before it is popped
    assign rd_data  = mem[rd_bin[pix_pkg::FIFO_PTR_BITS-2:0]];

    always_ff @(posedge rd_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_bin  <= '0;
            rd_gray <= '0;
        end else if (rd_pop) begin
            rd_bin  <= rd_bin + 1'b1;
            rd_gray <= bin2gray(rd_bin + 1'b1);
        end
    end

endmodule

/* src/pix_capture.sv */
`timescale 1ns/1ps

module pix_capture (
    input  logic                          pix_dclk,
    input  logic                          rst_n,
    input  logic                          arm,
    input  logic [pix_pkg::PIX_BITS-1:0]  pix_d,
    input  logic                          pix_fv,
    input  logic                          pix_lv,
    input  logic                          fifo_full,
    output logic                          fifo_wr_en,
    output logic [pix_pkg::WORD_BITS-1:0] fifo_wr_data
);

    pix_pkg::cap_state_e               state;
    logic [pix_pkg::PIX_BITS-1:0]      d_q;
    logic                              fv_q;
    logic                              lv_q;
    logic [pix_pkg::WORD_IDX_BITS-1:0] count;
    logic                              in_frame;
    logic                              take;

    // Pin registers
    always_ff @(posedge pix_dclk) begin
        d_q <= pix_d;
    end

    always_ff @(posedge pix_dclk or negedge rst_n) begin
        if (!rst_n) begin
            fv_q <= 1'b0;
            lv_q <= 1'b0;
        end else begin
            fv_q <= pix_fv;
            lv_q <= pix_lv;
        end
    end

    // Frame-valid seen high in CAP_WAIT_START is already the new frame
    assign in_frame = fv_q && (state == pix_pkg::CAP_WAIT_START ||
                               state == pix_pkg::CAP_STREAM);
    assign take     = in_frame && lv_q;

    // Dropped on a full FIFO, but still counted below
    assign fifo_wr_en   = take && !fifo_full;
    assign fifo_wr_data = {{(pix_pkg::WORD_BITS - pix_pkg::PIX_BITS){1'b0}}, d_q};

    always_ff @(posedge pix_dclk or negedge rst_n) begin
        if (!rst_n) begin
            state <= pix_pkg::CAP_IDLE;
            count <= '0;
        end else if (arm) begin
            state <= pix_pkg::CAP_WAIT_INVALID;
            count <= '0;
        end else begin
            if (take) begin
                count <= count + 1'b1;
            end
            case (state)
                pix_pkg::CAP_WAIT_INVALID: if (!fv_q) state <= pix_pkg::CAP_WAIT_START;
                pix_pkg::CAP_WAIT_START:   if (fv_q) state <= pix_pkg::CAP_STREAM;
                pix_pkg::CAP_STREAM:       if (!fv_q) state <= pix_pkg::CAP_IDLE;
                default: begin
                end
            endcase
            // Image complete
            if (take && count == pix_pkg::IMAGE_WORDS - 1) begin
                state <= pix_pkg::CAP_IDLE;
            end
        end
    end

endmodule

/* src/frame_ram_ctrl.sv */
`timescale 1ns/1ps

module frame_ram_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  pix_pkg::ram_cmd_e              cmd,
    input  logic [pix_pkg::BLOCK_BITS-1:0] cmd_block,
    input  logic                           write_trigger,
    input  logic [pix_pkg::WORD_BITS-1:0]  write_data,
    input  logic                           read_trigger,
    output logic                           write_ready,
    output logic                           write_done,
    output logic                           read_ready,
    output logic [pix_pkg::WORD_BITS-1:0]  read_data,
    output logic                           read_done
);

    logic [pix_pkg::WORD_BITS-1:0] mem [pix_pkg::BLOCK_COUNT * pix_pkg::IMAGE_WORDS];

    logic [pix_pkg::BLOCK_BITS-1:0]                         blk;
    logic [pix_pkg::WORD_IDX_BITS-1:0]                      widx;
    logic [pix_pkg::BLOCK_BITS+pix_pkg::WORD_IDX_BITS-1:0]  rd_addr;
    logic                                                   wr_accept;
    logic                                                   rd_accept;
    logic                                                   rd_fetch;

    assign wr_accept = write_ready && write_trigger;
    assign rd_accept = read_ready && read_trigger;

    // Word 0 is fetched on the read command, the next word on every accept
    assign rd_fetch = (cmd == pix_pkg::RAM_READ) || rd_accept;
    assign rd_addr  = (cmd == pix_pkg::RAM_READ) ?
                      {cmd_block, {pix_pkg::WORD_IDX_BITS{1'b0}}} :
                      {blk, widx + 1'b1};

    // ======================================================================
    // Storage
    // ======================================================================
    always_ff @(posedge clk) begin
        if (wr_accept) begin
            mem[{blk, widx}] <= write_data;
        end
        if (rd_fetch) begin
            read_data <= mem[rd_addr];
        end
    end

    // ======================================================================
    // Mode control
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            blk         <= '0;
            widx        <= '0;
            write_ready <= 1'b0;
            write_done  <= 1'b0;
            read_ready  <= 1'b0;
            read_done   <= 1'b0;
        end else begin
            write_done <= 1'b0;
            read_done  <= 1'b0;
            case (cmd)
                pix_pkg::RAM_WRITE: begin
                    blk         <= cmd_block;
                    widx        <= '0;
                    write_ready <= 1'b1;
                    read_ready  <= 1'b0;
                end
                pix_pkg::RAM_READ: begin
                    blk         <= cmd_block;
                    widx        <= '0;
                    read_ready  <= 1'b1;
                    write_ready <= 1'b0;
                end
                pix_pkg::RAM_STOP: begin
                    write_ready <= 1'b0;
                    read_ready  <= 1'b0;
                end
                default: begin
                    if (wr_accept || rd_accept) begin
                        widx <= widx + 1'b1;
                    end
                    if (wr_accept && widx == pix_pkg::IMAGE_WORDS - 1) begin
                        write_ready <= 1'b0;
                        write_done  <= 1'b1;
                    end
                    if (rd_accept && widx == pix_pkg::IMAGE_WORDS - 1) begin
                        read_ready <= 1'b0;
                        read_done  <= 1'b1;
                    end
                end
            endcase
        end
    end

endmodule

/* src/pix_ctrl.sv */
`timescale 1ns/1ps

module pix_ctrl (
    input  logic                           clk,
    input  logic                           rst_n,
    input  pix_pkg::pix_cmd_e              cmd,
    input  logic [pix_pkg::BLOCK_BITS-1:0] cmd_block,
    input  logic                           readout_trigger,
    input  logic                           pix_dclk,
    input  logic [pix_pkg::PIX_BITS-1:0]   pix_d,
    input  logic                           pix_fv,
    input  logic                           pix_lv,
    output logic                           capture_done,
    output logic                           readout_ready,
    output logic [pix_pkg::WORD_BITS-1:0]  readout_data,
    output logic                           readout_done
);

    pix_pkg::ctrl_state_e           state;
    pix_pkg::ram_cmd_e              ram_cmd;
    logic [pix_pkg::BLOCK_BITS-1:0] ram_block;
    logic                           arm;
    logic                           arm_pix;

    logic                           fifo_wr_en;
    logic [pix_pkg::WORD_BITS-1:0]  fifo_wr_data;
    logic                           fifo_full;
    logic                           fifo_rd_en;
    logic                           fifo_rd_valid;
    logic [pix_pkg::WORD_BITS-1:0]  fifo_rd_data;
    logic                           fifo_pop;

    logic                           write_trigger;
    logic [pix_pkg::WORD_BITS-1:0]  write_data;
    logic                           write_ready;
    logic                           write_done;
    logic                           read_ready;
    logic                           read_trigger;
    logic                           read_done;
    logic                           readout_active;

    // ======================================================================
    // Pixel clock side
    // ======================================================================
    toggle_sync i_arm_sync (
        .src_clk   (clk),
        .dst_clk   (pix_dclk),
        .rst_n     (rst_n),
        .src_pulse (arm),
        .dst_pulse (arm_pix)
    );

    pix_capture i_pix_capture (
        .pix_dclk     (pix_dclk),
        .rst_n        (rst_n),
        .arm          (arm_pix),
        .pix_d        (pix_d),
        .pix_fv       (pix_fv),
        .pix_lv       (pix_lv),
        .fifo_full    (fifo_full),
        .fifo_wr_en   (fifo_wr_en),
        .fifo_wr_data (fifo_wr_data)
    );

    pix_fifo i_pix_fifo (
        .wr_clk   (pix_dclk),
        .rd_clk   (clk),
        .rst_n    (rst_n),
        .wr_en    (fifo_wr_en),
        .wr_data  (fifo_wr_data),
        .rd_en    (fifo_rd_en),
        .full     (fifo_full),
        .rd_valid (fifo_rd_valid),
        .rd_data  (fifo_rd_data)
    );

    // ======================================================================
    // Frame store
    // ======================================================================
    frame_ram_ctrl i_frame_ram_ctrl (
        .clk           (clk),
        .rst_n         (rst_n),
        .cmd           (ram_cmd),
        .cmd_block     (ram_block),
        .write_trigger (write_trigger),
        .write_data    (write_data),
        .read_trigger  (read_trigger),
        .write_ready   (write_ready),
        .write_done    (write_done),
        .read_ready    (read_ready),
        .read_data     (readout_data),
        .read_done     (read_done)
    );

    // Readout port is only live while a readout runs, so a stop hides it at once
    assign readout_active = (state == pix_pkg::CTRL_READOUT);
    assign readout_ready  = read_ready && readout_active;
    assign read_trigger   = readout_trigger && readout_active;
    assign readout_done   = read_done && readout_active;

    // Pop only when the held word has gone or is going this cycle
    assign fifo_rd_en = (state == pix_pkg::CTRL_COPY) && (!write_trigger || write_ready);
    assign fifo_pop   = fifo_rd_en && fifo_rd_valid;

    always_ff @(posedge clk) begin
        if (fifo_pop) begin
            write_data <= fifo_rd_data;
        end
    end

    // ======================================================================
    // Command FSM
    // ======================================================================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= pix_pkg::CTRL_IDLE;
            ram_cmd       <= pix_pkg::RAM_NONE;
            ram_block     <= '0;
            arm           <= 1'b0;
            write_trigger <= 1'b0;
            capture_done  <= 1'b0;
        end else begin
            ram_cmd      <= pix_pkg::RAM_NONE;
            arm          <= 1'b0;
            capture_done <= 1'b0;
            case (state)
                pix_pkg::CTRL_IDLE: begin
                    if (cmd == pix_pkg::CMD_CAPTURE) begin
                        ram_block <= cmd_block;
                        state     <= pix_pkg::CTRL_CAPTURE;
                    end else if (cmd == pix_pkg::CMD_READOUT) begin
                        ram_block <= cmd_block;
                        ram_cmd   <= pix_pkg::RAM_READ;
                        state     <= pix_pkg::CTRL_READOUT;
                    end
                end
                pix_pkg::CTRL_CAPTURE: begin
                    ram_cmd <= pix_pkg::RAM_WRITE;
                    arm     <= 1'b1;
                    state   <= pix_pkg::CTRL_COPY;
                end
                pix_pkg::CTRL_COPY: begin
                    if (write_trigger && write_ready) begin
                        write_trigger <= 1'b0;
                    end
                    if (fifo_pop) begin
                        write_trigger <= 1'b1;
                    end
                    // Store has the full image
                    if (write_done) begin
                        write_trigger <= 1'b0;
                        capture_done  <= 1'b1;
                        state         <= pix_pkg::CTRL_IDLE;
                    end
                end
                pix_pkg::CTRL_READOUT: begin
                    if (cmd == pix_pkg::CMD_STOP) begin
                        ram_cmd <= pix_pkg::RAM_STOP;
                        state   <= pix_pkg::CTRL_IDLE;
                    end else if (read_done) begin
                        state <= pix_pkg::CTRL_IDLE;
                    end
                end
                default: state <= pix_pkg::CTRL_IDLE;
            endcase
        end
    end

endmodule

/* verif/tb_pix_ctrl.sv */
`timescale 1ns/1ps

module tb_pix_ctrl;

    // ======================================================================
    // Sensor timing and run limit
    // ======================================================================
    localparam int LINE_PIXELS      = 8;
    localparam int FRAME_LINES      = 10;
    localparam int LINE_GAP         = 4;
    localparam int FRAME_GAP        = 12;
    // Front porch, lines with their gaps, then the gap after the frame
    localparam int FRAME_PIX_CYCLES = LINE_GAP + FRAME_LINES * (LINE_PIXELS + LINE_GAP)
                                      + FRAME_GAP;
    localparam int FRAME_CLKS       = FRAME_PIX_CYCLES * 20 / 8;
    localparam int TIMEOUT_CYCLES   = 2 * (8 * FRAME_CLKS + 4 * 200);
    localparam logic [31:0] LFSR_MASK = 32'h8020_0003;

    typedef enum {M_IDLE, M_CAPTURE, M_RD_WAIT, M_READ, M_RD_DONE} model_state_e;

    logic                           clk = 1'b0;
    logic                           pix_dclk = 1'b0;
    logic                           rst_n;
    pix_pkg::pix_cmd_e              cmd;
    logic [pix_pkg::BLOCK_BITS-1:0] cmd_block;
    logic                           readout_trigger;
    logic [pix_pkg::PIX_BITS-1:0]   pix_d;
    logic                           pix_fv;
    logic                           pix_lv;
    logic                           capture_done;
    logic                           readout_ready;
    logic [pix_pkg::WORD_BITS-1:0]  readout_data;
    logic                           readout_done;

    logic [31:0]                    lfsr_state = 32'hcb54_ae92;
    int                             sensor_line = -1;
    int                             cycle_count = 0;
    logic [pix_pkg::WORD_BITS-1:0]  frame_q [$];
    logic [pix_pkg::WORD_BITS-1:0]  exp_words [pix_pkg::BLOCK_COUNT][pix_pkg::IMAGE_WORDS];

    // Reference model of the command and readout port
    model_state_e                   mdl_state = M_IDLE;
    int                             mdl_block = 0;
    int                             mdl_idx = 0;
    logic                           exp_ready = 1'b0;
    logic                           exp_done = 1'b0;

    pix_ctrl i_pix_ctrl (
        .clk             (clk),
        .rst_n           (rst_n),
        .cmd             (cmd),
        .cmd_block       (cmd_block),
        .readout_trigger (readout_trigger),
        .pix_dclk        (pix_dclk),
        .pix_d           (pix_d),
        .pix_fv          (pix_fv),
        .pix_lv          (pix_lv),
        .capture_done    (capture_done),
        .readout_ready   (readout_ready),
        .readout_data    (readout_data),
        .readout_done    (readout_done)
    );

    always #4 clk = ~clk;
    always #10 pix_dclk = ~pix_dclk;

    // ======================================================================
    // Helpers
    // ======================================================================
    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("*** FAILED ***");
        $fatal(1, "Simulation aborted");
    endtask

    task automatic value_error(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        fail_run($sformatf("ERR %0t ns: %s expected 0x%0h, got 0x%0h",
                           $time, name, expected, actual));
    endtask

    function automatic logic next_rand_bit();
        logic b;
        b = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (b) begin
            lfsr_state = lfsr_state ^ LFSR_MASK;
        end
        return b;
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] r;
        int          i;
        r = '0;
        for (i = 0; i < n; i++) begin
            r = {r[30:0], next_rand_bit()};
        end
        return r;
    endfunction

    // One frame of the sensor, optionally recording its line-valid pixels
    task automatic send_frame(input bit record);
        logic [pix_pkg::PIX_BITS-1:0] value;
        int                           line;
        int                           p;
        @(posedge pix_dclk);
        pix_fv <= 1'b1;
        repeat (LINE_GAP) @(posedge pix_dclk);
        for (line = 0; line < FRAME_LINES; line++) begin
            sensor_line = line;
            for (p = 0; p < LINE_PIXELS; p++) begin
                value = rand_bits(pix_pkg::PIX_BITS);
                pix_lv <= 1'b1;
                pix_d  <= value;
                if (record) begin
                    frame_q.push_back({{(pix_pkg::WORD_BITS - pix_pkg::PIX_BITS){1'b0}}, value});
                end
                @(posedge pix_dclk);
            end
            pix_lv <= 1'b0;
            repeat (LINE_GAP) @(posedge pix_dclk);
        end
        pix_fv <= 1'b0;
        sensor_line = -1;
        repeat (FRAME_GAP) @(posedge pix_dclk);
    endtask

    // First IMAGE_WORDS pixels of the recorded frame become the block image
    task automatic store_expected(input int blk);
        int i;
        for (i = 0; i < pix_pkg::IMAGE_WORDS; i++) begin
            exp_words[blk][i] = frame_q.pop_front();
        end
        frame_q.delete();
    endtask

    task automatic send_cmd(input pix_pkg::pix_cmd_e c,
                            input logic [pix_pkg::BLOCK_BITS-1:0] blk);
        @(posedge clk);
        cmd       <= c;
        cmd_block <= blk;
        @(posedge clk);
        cmd <= pix_pkg::CMD_NONE;
    endtask

    task automatic wait_capture_done();
        do @(posedge clk); while (capture_done !== 1'b1);
    endtask

    task automatic wait_readout_done();
        do @(posedge clk); while (readout_done !== 1'b1);
    endtask

    // Arm while a frame runs, with a readout that the busy controller drops
    task automatic capture_mid_frame(input int blk);
        fork
            begin
                send_frame(1'b0);
                send_frame(1'b1);
            end
            begin
                wait (sensor_line == 3);
                send_cmd(pix_pkg::CMD_CAPTURE, blk);
                repeat (4) @(posedge clk);
                send_cmd(pix_pkg::CMD_READOUT, 3);
                wait_capture_done();
            end
        join
        store_expected(blk);
    endtask

    task automatic capture_block(input int blk);
        send_cmd(pix_pkg::CMD_CAPTURE, blk);
        // Arm crosses into the pixel domain before the frame starts
        repeat (24) @(posedge clk);
        fork
            send_frame(1'b1);
            wait_capture_done();
        join
        store_expected(blk);
    endtask

    task automatic read_block(input int blk);
        send_cmd(pix_pkg::CMD_READOUT, blk);
        wait_readout_done();
        repeat (4) @(posedge clk);
    endtask

    task automatic read_then_stop(input int blk, input int words);
        int taken;
        taken = 0;
        send_cmd(pix_pkg::CMD_READOUT, blk);
        while (taken < words) begin
            @(posedge clk);
            if (readout_ready && readout_trigger) begin
                taken++;
            end
        end
        cmd <= pix_pkg::CMD_STOP;
        @(posedge clk);
        cmd <= pix_pkg::CMD_NONE;
        repeat (80) @(posedge clk);
    endtask

    // ======================================================================
    // Readout stalls and run limit
    // ======================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            readout_trigger <= 1'b0;
        end else begin
            readout_trigger <= next_rand_bit();
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count == TIMEOUT_CYCLES) begin
            fail_run("Timeout: the test sequence did not finish in time");
        end
    end

    // ======================================================================
    // Checks against the reference model
    // ======================================================================
    always @(posedge clk) begin
        if (!rst_n) begin
            assert (!capture_done && !readout_ready && !readout_done)
            else fail_run("Outputs were not low during reset");
            mdl_state = M_IDLE;
            exp_ready = 1'b0;
            exp_done  = 1'b0;
        end else begin
            assert (readout_ready == exp_ready)
            else value_error("readout_ready", exp_ready, readout_ready);
            assert (readout_done == exp_done)
            else value_error("readout_done", exp_done, readout_done);
            assert (!capture_done || mdl_state == M_CAPTURE)
            else fail_run("capture_done pulsed with no capture in progress");
            if (exp_ready) begin
                assert (readout_data == exp_words[mdl_block][mdl_idx])
                else value_error("readout_data", exp_words[mdl_block][mdl_idx], readout_data);
            end

            if (capture_done) begin
                mdl_state = M_IDLE;
            end

            // Expected port state for the cycle that starts now
            exp_done = 1'b0;
            case (mdl_state)
                M_IDLE: begin
                    if (cmd == pix_pkg::CMD_CAPTURE) begin
                        mdl_state = M_CAPTURE;
                    end else if (cmd == pix_pkg::CMD_READOUT) begin
                        mdl_block = cmd_block;
                        mdl_idx   = 0;
                        mdl_state = M_RD_WAIT;
                    end
                end
                M_RD_WAIT: begin
                    if (cmd == pix_pkg::CMD_STOP) begin
                        mdl_state = M_IDLE;
                    end else begin
                        exp_ready = 1'b1;
                        mdl_state = M_READ;
                    end
                end
                M_READ: begin
                    if (cmd == pix_pkg::CMD_STOP) begin
                        exp_ready = 1'b0;
                        mdl_state = M_IDLE;
                    end else if (readout_trigger) begin
                        if (mdl_idx == pix_pkg::IMAGE_WORDS - 1) begin
                            exp_ready = 1'b0;
                            exp_done  = 1'b1;
                            mdl_state = M_RD_DONE;
                        end else begin
                            mdl_idx++;
                        end
                    end
                end
                M_RD_DONE: mdl_state = M_IDLE;
                default: begin
                end
            endcase
        end
    end

    // ======================================================================
    // Test sequence
    // ======================================================================
    initial begin
        rst_n     = 1'b1;
        cmd       = pix_pkg::CMD_NONE;
        cmd_block = '0;
        pix_d     = '0;
        pix_fv    = 1'b0;
        pix_lv    = 1'b0;
        readout_trigger = 1'b0;
        #1;
        rst_n = 1'b0;
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        repeat (20) @(posedge clk);

        capture_mid_frame(0);
        read_block(0);
        capture_block(1);
        capture_block(2);
        read_block(1);
        read_block(2);
        // Block 0 keeps its image after the later captures
        read_block(0);
        read_then_stop(2, 20);
        read_block(2);
        repeat (10) @(posedge clk);

        $display("*** PASSED ***");
        $finish;
    end

endmodule

/* compile.f */
src/pix_pkg.sv
src/toggle_sync.sv
src/pix_fifo.sv
src/pix_capture.sv
src/frame_ram_ctrl.sv
src/pix_ctrl.sv
verif/tb_pix_ctrl.sv

/* Bender.yml */
package:
  name: pix_ctrl

sources:
  - src/pix_pkg.sv
  - src/toggle_sync.sv
  - src/pix_fifo.sv
  - src/pix_capture.sv
  - src/frame_ram_ctrl.sv
  - src/pix_ctrl.sv
  - target: test
    files:
      - verif/tb_pix_ctrl.sv
